/* list.f */
src/axis_in_pkg.sv
src/cdc_sync.sv
src/axis_in_packer.sv
src/async_fifo.sv
src/axis_in_csrs.sv
src/axis_in_top.sv
verif/axis_in_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then scan the log for failure

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

{ verilator --binary --timing --assert -Wno-fatal --top-module axis_in_tb -f list.f \
   && ./obj_dir/Vaxis_in_tb; } > sim.log 2>&1 \
   || echo "TESTBENCH FAILED" >> sim.log

cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
   || echo "Simulation passed"
exit 0

/* src/async_fifo.sv */
// Dual-clock FIFO of bus words with gray-coded pointers
// First-word fall-through read port, level and full flag on the read side

`timescale 1ns/1ns

module async_fifo #(
   parameter int FIFO_ADDR_W = 4
) (
   // Write side
   input  logic                   w_clk_i,
   input  logic                   w_rst_n_i,
   input  logic                   w_soft_rst_i,
   input  logic                   w_en_i,
   input  axis_in_pkg::bus_word_t w_data_i,
   output logic                   w_full_o,
   // Read side
   input  logic                   r_clk_i,
   input  logic                   r_rst_n_i,
   input  logic                   r_soft_rst_i,
   input  logic                   r_en_i,
   output axis_in_pkg::bus_word_t r_data_o,
   output logic                   r_empty_o,
   output logic                   r_full_o,
   output logic [FIFO_ADDR_W:0]   r_level_o
);

   import axis_in_pkg::*;

   localparam int DEPTH = 1 << FIFO_ADDR_W;
   localparam int PTR_W = FIFO_ADDR_W + 1;

   bus_word_t mem_q [DEPTH];

   logic [PTR_W-1:0] w_bin_q;
   logic [PTR_W-1:0] w_bin_nxt;
   logic [PTR_W-1:0] w_gray_q;
   logic [PTR_W-1:0] r_gray_w;
   logic [PTR_W-1:0] r_bin_w;
   logic [PTR_W-1:0] w_level;
   bus_word_t        r_bin_w_wide;
   logic             w_push;

   logic [PTR_W-1:0] r_bin_q;
   logic [PTR_W-1:0] r_bin_nxt;
   logic [PTR_W-1:0] r_gray_q;
   logic [PTR_W-1:0] w_gray_r;
   logic [PTR_W-1:0] w_bin_r;
   bus_word_t        w_bin_r_wide;
   logic             r_pop;

   // Write domain
   assign r_bin_w_wide = gray2bin(bus_word_t'(r_gray_w));
   assign r_bin_w      = r_bin_w_wide[PTR_W-1:0];
   assign w_level      = w_bin_q - r_bin_w;
   assign w_full_o     = (w_level == PTR_W'(DEPTH));
   assign w_push       = w_en_i && !w_full_o;
   assign w_bin_nxt    = w_bin_q + 1'b1;

   always_ff @(posedge w_clk_i) begin
      if (w_push) begin
         mem_q[w_bin_q[FIFO_ADDR_W-1:0]] <= w_data_i;
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (!w_rst_n_i || w_soft_rst_i) begin
         w_bin_q  <= '0;
         w_gray_q <= '0;
      end else if (w_push) begin
         w_bin_q  <= w_bin_nxt;
         w_gray_q <= w_bin_nxt ^ (w_bin_nxt >> 1);
      end
   end

   // Read domain
   assign w_bin_r_wide = gray2bin(bus_word_t'(w_gray_r));
   assign w_bin_r      = w_bin_r_wide[PTR_W-1:0];
   assign r_level_o    = w_bin_r - r_bin_q;
   assign r_empty_o    = (r_level_o == '0);
   assign r_full_o     = (r_level_o == PTR_W'(DEPTH));
   assign r_pop        = r_en_i && !r_empty_o;
   assign r_bin_nxt    = r_bin_q + 1'b1;

   // Head word straight from the array
   assign r_data_o = mem_q[r_bin_q[FIFO_ADDR_W-1:0]];

   always_ff @(posedge r_clk_i) begin
      if (!r_rst_n_i || r_soft_rst_i) begin
         r_bin_q  <= '0;
         r_gray_q <= '0;
      end else if (r_pop) begin
         r_bin_q  <= r_bin_nxt;
         r_gray_q <= r_bin_nxt ^ (r_bin_nxt >> 1);
      end
   end

   cdc_sync #(.W(PTR_W)) wptr_sync (
      .clk_i   (r_clk_i),
      .rst_n_i (r_rst_n_i),
      .signal_i(w_gray_q),
      .signal_o(w_gray_r)
   );

   cdc_sync #(.W(PTR_W)) rptr_sync (
      .clk_i   (w_clk_i),
      .rst_n_i (w_rst_n_i),
      .signal_i(r_gray_q),
      .signal_o(r_gray_w)
   );

   a_no_read_empty: assert property (@(posedge r_clk_i) disable iff (!r_rst_n_i)
      !(r_en_i && r_empty_o));

   a_no_write_full: assert property (@(posedge w_clk_i) disable iff (!w_rst_n_i)
      !(w_en_i && w_full_o));

endmodule

/* src/axis_in_csrs.sv */
// Register file: control, data pop, status, beat count, level, threshold
// Registered read data and level-threshold interrupt

`timescale 1ns/1ns

module axis_in_csrs #(
   parameter int FIFO_ADDR_W = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_n_i,
   input  axis_in_pkg::csr_req_t  csr_req_i,
   input  axis_in_pkg::bus_word_t fifo_rdata_i,
   input  logic                   fifo_empty_i,
   input  logic                   fifo_full_i,
   input  logic [FIFO_ADDR_W:0]   fifo_level_i,
   input  axis_in_pkg::bus_word_t beat_count_gray_i,
   input  logic                   tlast_detected_i,
   output axis_in_pkg::bus_word_t csr_rdata_o,
   output logic                   csr_rvalid_o,
   output axis_in_pkg::ctrl_t     ctrl_o,
   output logic                   fifo_read_o,
   output logic                   interrupt_o
);

   import axis_in_pkg::*;

   localparam int DEPTH = 1 << FIFO_ADDR_W;

   ctrl_t     ctrl_q;
   bus_word_t thresh_q;
   bus_word_t level_w;
   bus_word_t rdata_nxt;
   bus_word_t rdata_q;
   status_t   status;
   logic      rvalid_q;
   logic      irq_q;

   assign level_w = bus_word_t'(fifo_level_i);

   assign status.empty          = fifo_empty_i;
   assign status.full           = fifo_full_i;
   assign status.tlast_detected = tlast_detected_i;

   // Pop in the strobe cycle, never from an empty FIFO
   assign fifo_read_o = csr_req_i.ren && (csr_req_i.addr == CSR_DATA) && !fifo_empty_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ctrl_q   <= '0;
         thresh_q <= bus_word_t'(DEPTH + 1);
      end else if (csr_req_i.wen) begin
         if (csr_req_i.addr == CSR_CTRL) begin
            ctrl_q <= ctrl_t'(csr_req_i.wdata[1:0]);
         end
         if (csr_req_i.addr == CSR_THRESH) begin
            thresh_q <= csr_req_i.wdata;
         end
      end
   end

   always_comb begin
      case (csr_req_i.addr)
         CSR_CTRL:   rdata_nxt = bus_word_t'(ctrl_q);
         CSR_DATA:   rdata_nxt = fifo_empty_i ? '0 : fifo_rdata_i;
         CSR_STATUS: rdata_nxt = bus_word_t'(status);
         CSR_NBEATS: rdata_nxt = gray2bin(beat_count_gray_i);
         CSR_LEVEL:  rdata_nxt = level_w;
         CSR_THRESH: rdata_nxt = thresh_q;
         default:    rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (csr_req_i.ren) begin
         rdata_q <= rdata_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
         irq_q    <= 1'b0;
      end else begin
         rvalid_q <= csr_req_i.ren;
         irq_q    <= (level_w >= thresh_q);
      end
   end

   assign csr_rdata_o  = rdata_q;
   assign csr_rvalid_o = rvalid_q;
   assign ctrl_o       = ctrl_q;
   assign interrupt_o  = irq_q;

endmodule

/* src/axis_in_packer.sv */
// Stream-domain AXI-Stream slave: beat acceptance and little-endian lane packing
// Zero padding on tlast, sticky tlast flag, gray-coded beat counter

`timescale 1ns/1ns

module axis_in_packer #(
   parameter int TDATA_W = 8
) (
   input  logic                   axis_clk_i,
   input  logic                   rst_n_i,
   input  axis_in_pkg::ctrl_t     ctrl_i,
   input  logic                   axis_tvalid_i,
   input  logic [TDATA_W-1:0]     axis_tdata_i,
   input  logic                   axis_tlast_i,
   input  logic                   wr_full_i,
   output logic                   axis_tready_o,
   output logic                   wr_en_o,
   output axis_in_pkg::bus_word_t wr_data_o,
   output logic                   tlast_detected_o,
   output axis_in_pkg::bus_word_t beat_count_gray_o
);

   import axis_in_pkg::*;

   // Lanes per word
   localparam int R      = BUS_W / TDATA_W;
   localparam int LANE_W = (R > 1) ? $clog2(R) : 1;

   pack_state_e       state_q;
   logic [LANE_W-1:0] lane_q;
   bus_word_t         word_q;
   logic              tlast_q;
   bus_word_t         count_q;
   bus_word_t         count_nxt;
   bus_word_t         gray_q;
   logic              beat_acc;
   logic              last_lane;

   assign axis_tready_o = (state_q == ST_FILL) && ctrl_i.enable && !tlast_q &&
                          !ctrl_i.soft_reset;
   assign beat_acc      = axis_tvalid_i && axis_tready_o;
   assign last_lane     = (int'(lane_q) == R - 1);

   // Held word goes out as soon as the FIFO has room
   assign wr_en_o   = (state_q == ST_FLUSH) && !wr_full_i;
   assign wr_data_o = word_q;

   always_ff @(posedge axis_clk_i) begin
      if (!rst_n_i || ctrl_i.soft_reset) begin
         state_q <= ST_FILL;
         lane_q  <= '0;
         word_q  <= '0;
      end else begin
         case (state_q)
            ST_FILL: begin
               if (beat_acc) begin
                  word_q[int'(lane_q)*TDATA_W +: TDATA_W] <= axis_tdata_i;
                  if (last_lane || axis_tlast_i) begin
                     state_q <= ST_FLUSH;
                     lane_q  <= '0;
                  end else begin
                     lane_q <= lane_q + 1'b1;
                  end
               end
            end
            ST_FLUSH: begin
               // Clear all lanes so a short word pads with zeros
               if (!wr_full_i) begin
                  state_q <= ST_FILL;
                  word_q  <= '0;
               end
            end
            default: state_q <= ST_FILL;
         endcase
      end
   end

   assign count_nxt = count_q + 1'b1;

   // Beat count and sticky tlast
   always_ff @(posedge axis_clk_i) begin
      if (!rst_n_i || ctrl_i.soft_reset) begin
         count_q <= '0;
         gray_q  <= '0;
         tlast_q <= 1'b0;
      end else if (beat_acc) begin
         count_q <= count_nxt;
         gray_q  <= count_nxt ^ (count_nxt >> 1);
         if (axis_tlast_i) begin
            tlast_q <= 1'b1;
         end
      end
   end

   assign tlast_detected_o  = tlast_q;
   assign beat_count_gray_o = gray_q;

   a_lane_in_range: assert property (@(posedge axis_clk_i) disable iff (!rst_n_i)
      int'(lane_q) < R);

endmodule

/* src/axis_in_pkg.sv */
// Shared definitions for the stream-input peripheral
// Register map, bus typedefs, control/status structs, packer states, gray decode

package axis_in_pkg;

   // Register and packed-word width
   localparam int BUS_W      = 32;
   localparam int CSR_ADDR_W = 3;

   typedef logic [BUS_W-1:0]      bus_word_t;
   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   // Word addresses
   localparam csr_addr_t CSR_CTRL   = 3'd0;
   localparam csr_addr_t CSR_DATA   = 3'd1;
   localparam csr_addr_t CSR_STATUS = 3'd2;
   localparam csr_addr_t CSR_NBEATS = 3'd3;
   localparam csr_addr_t CSR_LEVEL  = 3'd4;
   localparam csr_addr_t CSR_THRESH = 3'd5;

   typedef struct packed {
      logic      wen;
      logic      ren;
      csr_addr_t addr;
      bus_word_t wdata;
   } csr_req_t;

   // Enable is bit 1, soft reset is bit 0
   typedef struct packed {
      logic enable;
      logic soft_reset;
   } ctrl_t;

   // Empty in bit 2, full in bit 1, tlast in bit 0
   typedef struct packed {
      logic empty;
      logic full;
      logic tlast_detected;
   } status_t;

   typedef enum logic {
      ST_FILL,
      ST_FLUSH
   } pack_state_e;

   function automatic bus_word_t gray2bin(input bus_word_t gray);
      bus_word_t bin;
      bin[BUS_W-1] = gray[BUS_W-1];
      for (int i = BUS_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

/* src/axis_in_top.sv */
// Stream-input peripheral top level
// Packer, dual-clock FIFO, domain-crossing synchronizers and register file

`timescale 1ns/1ns

module axis_in_top #(
   parameter int TDATA_W     = 8,
   parameter int FIFO_ADDR_W = 4
) (
   input  logic                   clk_i,
   input  logic                   axis_clk_i,
   input  logic                   rst_n_i,
   input  axis_in_pkg::csr_req_t  csr_req_i,
   input  logic                   axis_tvalid_i,
   input  logic [TDATA_W-1:0]     axis_tdata_i,
   input  logic                   axis_tlast_i,
   output logic                   axis_tready_o,
   output axis_in_pkg::bus_word_t csr_rdata_o,
   output logic                   csr_rvalid_o,
   output logic                   interrupt_o
);

   import axis_in_pkg::*;

   // Register domain
   ctrl_t                ctrl_clk;
   bus_word_t            count_gray_clk;
   logic                 tlast_clk;
   bus_word_t            rd_data;
   logic                 rd_empty;
   logic                 rd_full;
   logic [FIFO_ADDR_W:0] rd_level;
   logic                 rd_en;

   // Stream domain
   ctrl_t                ctrl_axis;
   logic                 wr_en;
   bus_word_t            wr_data;
   logic                 wr_full;
   bus_word_t            count_gray_axis;
   logic                 tlast_axis;

   axis_in_csrs #(.FIFO_ADDR_W(FIFO_ADDR_W)) csrs (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .csr_req_i        (csr_req_i),
      .fifo_rdata_i     (rd_data),
      .fifo_empty_i     (rd_empty),
      .fifo_full_i      (rd_full),
      .fifo_level_i     (rd_level),
      .beat_count_gray_i(count_gray_clk),
      .tlast_detected_i (tlast_clk),
      .csr_rdata_o      (csr_rdata_o),
      .csr_rvalid_o     (csr_rvalid_o),
      .ctrl_o           (ctrl_clk),
      .fifo_read_o      (rd_en),
      .interrupt_o      (interrupt_o)
   );

   axis_in_packer #(.TDATA_W(TDATA_W)) packer (
      .axis_clk_i       (axis_clk_i),
      .rst_n_i          (rst_n_i),
      .ctrl_i           (ctrl_axis),
      .axis_tvalid_i    (axis_tvalid_i),
      .axis_tdata_i     (axis_tdata_i),
      .axis_tlast_i     (axis_tlast_i),
      .wr_full_i        (wr_full),
      .axis_tready_o    (axis_tready_o),
      .wr_en_o          (wr_en),
      .wr_data_o        (wr_data),
      .tlast_detected_o (tlast_axis),
      .beat_count_gray_o(count_gray_axis)
   );

   async_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) fifo (
      .w_clk_i     (axis_clk_i),
      .w_rst_n_i   (rst_n_i),
      .w_soft_rst_i(ctrl_axis.soft_reset),
      .w_en_i      (wr_en),
      .w_data_i    (wr_data),
      .w_full_o    (wr_full),
      .r_clk_i     (clk_i),
      .r_rst_n_i   (rst_n_i),
      .r_soft_rst_i(ctrl_clk.soft_reset),
      .r_en_i      (rd_en),
      .r_data_o    (rd_data),
      .r_empty_o   (rd_empty),
      .r_full_o    (rd_full),
      .r_level_o   (rd_level)
   );

   cdc_sync #(.W(2)) ctrl_sync (
      .clk_i   (axis_clk_i),
      .rst_n_i (rst_n_i),
      .signal_i(ctrl_clk),
      .signal_o(ctrl_axis)
   );

   cdc_sync #(.W(BUS_W)) count_sync (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .signal_i(count_gray_axis),
      .signal_o(count_gray_clk)
   );

   cdc_sync #(.W(1)) tlast_sync (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .signal_i(tlast_axis),
      .signal_o(tlast_clk)
   );

endmodule

/* src/cdc_sync.sv */
// Two-flop synchronizer for a W-bit level or gray-coded value

`timescale 1ns/1ns

module cdc_sync #(
   parameter int W = 1
) (
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  logic [W-1:0] signal_i,
   output logic [W-1:0] signal_o
);

   logic [W-1:0] meta_q;
   logic [W-1:0] sync_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= signal_i;
         sync_q <= meta_q;
      end
   end

   assign signal_o = sync_q;

endmodule

/* verif/axis_in_input.txt */
# columns: command then hex values, a comment names the section by its first word
# W addr data | R addr expected | S tdata tlast | N beats first | D words first | P cycles | I irq | T tready
# reset_state
R 2 4
R 3 0
R 4 0
I 0
T 0
P 8
T 0
# packing_order
W 0 2
P 4
T 1
N 8 10
P c
R 4 2
R 3 8
R 1 13121110
R 1 17161514
R 1 0
# level_interrupt
N c a0
P c
R 4 3
R 3 14
I 0
W 5 3
P 4
I 1
R 1 a3a2a1a0
P 4
I 0
W 5 2
P 4
I 1
R 1 a7a6a5a4
R 1 abaaa9a8
P c
R 4 0
I 0
W 5 11
# back_pressure
N 44 0
P c
R 2 2
R 4 10
T 0
D 11 0
N 8 44
P c
D 2 44
R 2 4
R 3 60
# padding_tlast
S 1 0
S 2 0
S 3 1
P c
R 2 1
R 3 63
R 4 1
T 0
# soft_reset
W 0 3
P c
W 0 2
P c
R 2 4
R 3 0
R 4 0
R 1 0
I 0
# new_stream
S aa 0
S bb 1
P c
R 3 2
R 1 0000bbaa
R 2 5

/* verif/axis_in_tb.sv */
// Testbench for the stream-input peripheral
// Clocks, reset, file-driven register and stream stimulus, value checks, timeout

`timescale 1ns/1ns

module axis_in_tb;

   import axis_in_pkg::*;

   localparam int    TDATA_W     = 8;
   localparam int    FIFO_ADDR_W = 4;
   localparam int    LANES       = BUS_W / TDATA_W;
   localparam int    CYCLES_LINE = 64;
   localparam string INPUT_FILE  = "verif/axis_in_input.txt";

   logic               clk;
   logic               axis_clk;
   logic               rst_n;
   csr_req_t           csr_req;
   logic               tvalid;
   logic [TDATA_W-1:0] tdata;
   logic               tlast;
   logic               tready;
   bus_word_t          csr_rdata;
   logic               csr_rvalid;
   logic               irq;

   logic [31:0]        lcg_state;
   int                 cycle_count;
   int                 cycle_limit;

   axis_in_top #(.TDATA_W(TDATA_W), .FIFO_ADDR_W(FIFO_ADDR_W)) UUT (
      .clk_i        (clk),
      .axis_clk_i   (axis_clk),
      .rst_n_i      (rst_n),
      .csr_req_i    (csr_req),
      .axis_tvalid_i(tvalid),
      .axis_tdata_i (tdata),
      .axis_tlast_i (tlast),
      .axis_tready_o(tready),
      .csr_rdata_o  (csr_rdata),
      .csr_rvalid_o (csr_rvalid),
      .interrupt_o  (irq)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #10 clk = ~clk;
      end
   end

   // Stream clock trails the register clock by 5 ns
   initial begin
      axis_clk = 1'b0;
      #5;
      forever begin
         #10 axis_clk = ~axis_clk;
      end
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Little-endian word of consecutive beat values, lane 0 first
   function automatic bus_word_t packed_word(input bus_word_t first_beat);
      bus_word_t word;
      bus_word_t beat;
      word = '0;
      for (int lane = 0; lane < LANES; lane++) begin
         beat = first_beat + bus_word_t'(lane);
         word[lane*TDATA_W +: TDATA_W] = beat[TDATA_W-1:0];
      end
      return word;
   endfunction

   task automatic report_failure(input string reason);
      $display("%s", reason);
      $display("TESTBENCH FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input bus_word_t expected,
                              input bus_word_t actual);
      if (expected !== actual) begin
         report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                  name, expected, actual));
      end
   endtask

   task automatic write_reg(input csr_addr_t reg_addr, input bus_word_t data);
      @(posedge clk);
      csr_req <= '{wen: 1'b1, ren: 1'b0, addr: reg_addr, wdata: data};
      @(posedge clk);
      csr_req <= '0;
   endtask

   // Read data comes back exactly one cycle after the strobe
   task automatic read_reg(input string name, input csr_addr_t reg_addr,
                           output bus_word_t data);
      @(posedge clk);
      csr_req <= '{wen: 1'b0, ren: 1'b1, addr: reg_addr, wdata: '0};
      @(negedge clk);
      check_value($sformatf("%s rvalid before strobe", name), '0, bus_word_t'(csr_rvalid));
      @(posedge clk);
      csr_req <= '0;
      @(negedge clk);
      check_value($sformatf("%s rvalid after strobe", name), 32'd1, bus_word_t'(csr_rvalid));
      data = csr_rdata;
   endtask

   // Random idle gap, then hold the beat until the slave takes it
   task automatic drive_beat(input bus_word_t data, input logic last);
      logic accepted;
      lcg_state = lcg_next(lcg_state);
      repeat (lcg_state[31:30]) @(posedge axis_clk);
      @(posedge axis_clk);
      tvalid <= 1'b1;
      tdata  <= data[TDATA_W-1:0];
      tlast  <= last;
      accepted = 1'b0;
      while (!accepted) begin
         @(negedge axis_clk);
         accepted = tready;
         @(posedge axis_clk);
      end
      tvalid <= 1'b0;
      tlast  <= 1'b0;
   endtask

   task automatic run_command(input logic [7:0] cmd, input bus_word_t arg_a,
                              input bus_word_t arg_b, input string name);
      bus_word_t rdata;
      case (cmd)
         "W": write_reg(csr_addr_t'(arg_a), arg_b);
         "R": begin
            read_reg(name, csr_addr_t'(arg_a), rdata);
            check_value(name, arg_b, rdata);
         end
         "S": drive_beat(arg_a, arg_b[0]);
         "N": begin
            for (int i = 0; i < int'(arg_a); i++) begin
               drive_beat(arg_b + bus_word_t'(i), 1'b0);
            end
         end
         "D": begin
            for (int j = 0; j < int'(arg_a); j++) begin
               read_reg($sformatf("%s word %0d", name, j), CSR_DATA, rdata);
               check_value($sformatf("%s word %0d", name, j),
                           packed_word(arg_b + bus_word_t'(j * LANES)), rdata);
            end
         end
         "P": repeat (arg_a) @(posedge clk);
         "I": begin
            @(negedge clk);
            check_value(name, arg_a, bus_word_t'(irq));
         end
         "T": begin
            @(negedge axis_clk);
            check_value(name, arg_a, bus_word_t'(tready));
         end
         default: report_failure($sformatf("Unknown command %c in the stimulus file", cmd));
      endcase
   endtask

   initial begin : watchdog
      cycle_count = 0;
      forever begin
         @(posedge clk);
         cycle_count++;
         if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            report_failure($sformatf("Timeout: the tests did not finish within %0d cycles",
                                     cycle_limit));
         end
      end
   end

   initial begin : main
      int                 fd;
      int                 code;
      int                 n_lines;
      int                 step;
      logic               done;
      logic [7:0]         cmd;
      logic [8*128-1:0]   line_buf;
      logic [8*32-1:0]    section_tok;
      string              section;
      bus_word_t          arg_a;
      bus_word_t          arg_b;

      rst_n       = 1'b0;
      csr_req     = '0;
      tvalid      = 1'b0;
      tdata       = '0;
      tlast       = 1'b0;
      lcg_state   = 32'hf1a948b3;
      cycle_limit = 0;
      section     = "start";
      step        = 0;

      // First pass only sizes the timeout
      fd = $fopen(INPUT_FILE, "r");
      if (fd == 0) begin
         report_failure("Could not open the stimulus file");
      end
      n_lines = 0;
      while ($fgets(line_buf, fd) != 0) begin
         n_lines++;
      end
      $fclose(fd);
      cycle_limit = n_lines * CYCLES_LINE + 16;

      fd = $fopen(INPUT_FILE, "r");
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      done = 1'b0;
      while (!done) begin
         code = $fscanf(fd, " %c", cmd);
         if (code != 1) begin
            done = 1'b1;
         end else if (cmd == "#") begin
            // First word of a comment names the section
            code = $fscanf(fd, " %s", section_tok);
            code = $fgets(line_buf, fd);
            section = string'(section_tok);
            step = 0;
         end else begin
            step++;
            arg_b = '0;
            code = $fscanf(fd, " %h", arg_a);
            if (code == 1 && cmd inside {"W", "R", "S", "N", "D"}) begin
               code = $fscanf(fd, " %h", arg_b);
            end
            if (code != 1) begin
               report_failure($sformatf("Malformed %c line in section %s", cmd, section));
            end
            run_command(cmd, arg_a, arg_b, $sformatf("%s step %0d (%c)", section, step, cmd));
         end
      end
      $fclose(fd);

      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
